// File: source/cpc_pkg.sv
// CPC expansion package
// Memory map constants, Multiface Two shadow addresses and the
// download address decode shared by the loader, page map and Multiface

package cpc_pkg;

	// Boot memory address: bit 22 expansion flag, 21..14 page, 13..0 offset
	typedef logic [22:0] boot_addr_t;

	// Download address, read as a system slot or as an expansion page
	typedef union packed {
		struct packed {
			logic [10:0] slot;    // 16 KB slot for the system ROM file
			logic [13:0] offset;
		} sys;
		struct packed {
			logic [2:0]  unused;
			logic [7:0]  page;    // Page offset within an expansion file
			logic [13:0] offset;
		} exp;
	} dl_addr_t;

	//////////////////////////////////////////////////////////////////////
	// Boot memory layout
	localparam logic [8:0] SLOT_BASE_OS     = 9'h000;
	localparam logic [8:0] SLOT_BASE_BASIC  = 9'h100;
	localparam logic [8:0] SLOT_BASE_AMSDOS = 9'h107;
	localparam logic [8:0] SLOT_BASE_MF2    = 9'h1FF;
	localparam logic [8:0] PAGE_BAD_EXT     = 9'h1EE; // Spare page for a bad extension

	//////////////////////////////////////////////////////////////////////
	// Multiface Two decode
	localparam logic [13:0] MF2_PORT_HI     = 14'b11111110111010; // FEE8 and FEEA
	localparam logic [15:0] MF2_NMI_VECTOR  = 16'h0066;
	localparam logic [15:0] MF2_HIDE_VECTOR = 16'h0065;

	// Where hardware register writes are mirrored in the 8 KB RAM
	localparam logic [12:0] MF2_SHADOW_PEN       = 13'h1FCF;
	localparam logic [12:0] MF2_SHADOW_BORDER    = 13'h1FDF;
	localparam logic [12:0] MF2_SHADOW_PEN_BASE  = 13'h1F90; // Plus pen index
	localparam logic [12:0] MF2_SHADOW_MODE      = 13'h1FEF;
	localparam logic [12:0] MF2_SHADOW_BANK      = 13'h1FFF;
	localparam logic [12:0] MF2_SHADOW_CRTC_SEL  = 13'h1CFF;
	localparam logic [12:0] MF2_SHADOW_CRTC_BASE = 13'h1DB0; // Plus CRTC register
	localparam logic [12:0] MF2_SHADOW_PPI       = 13'h17FF;
	localparam logic [12:0] MF2_SHADOW_UROM      = 13'h1AAC;

	// Multiface configuration from the host menu
	typedef enum logic [1:0] {
		ENABLED  = 2'd0,
		HIDDEN   = 2'd1,
		DISABLED = 2'd2
	} mf2_mode_t;

endpackage

// File: source/cpu_bus_if.sv
// CPU bus interface
// Carries the Z80 address, write data and memory strobes from the top
// level to the Multiface and the ROM page map

interface cpu_bus_if;
	import cpc_pkg::*;

	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dout;  // Data driven by the CPU
	boot_addr_t  mem_addr;  // Mapped memory address
	logic        mem_rd;
	logic        mem_wr;
	logic        io_wr;
	logic        m1;        // Opcode fetch

	// Multiface sees the whole bus
	modport sink (
		input cpu_addr,
		input cpu_dout,
		input mem_addr,
		input mem_rd,
		input mem_wr,
		input io_wr,
		input m1
	);

	// Page map only needs the mapped address
	modport map_sink (
		input mem_addr
	);

endinterface

// File: source/rom_loader.sv
// ROM download loader
// Maps host download bytes onto boot memory writes. System ROM slots
// go to fixed pages, expansion files to the page named by the file
// extension, with an optional second write into bank 1

module rom_loader (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              download,
	input  logic              ioctl_wr,
	input  logic [7:0]        ioctl_index,
	input  cpc_pkg::dl_addr_t ioctl_addr,
	input  logic [7:0]        ioctl_data,
	input  logic [15:0]       ioctl_ext,
	output logic              dl_wait,
	output logic              boot_wr,
	output cpc_pkg::boot_addr_t boot_addr,
	output logic [1:0]        boot_bank,
	output logic [7:0]        boot_data,
	output logic              page_mark,
	output logic [7:0]        page_mark_page
);
	import cpc_pkg::*;

	logic [2:0] div;
	logic       ref_en;        // One cycle in eight
	logic       old_download;
	logic       rom_dl;
	logic       byte_in;
	logic       slot_ok;
	logic       two_bank;
	logic       bank_step;
	logic [8:0] sys_base;
	logic [8:0] ext_page;
	logic [8:0] page;          // Latched at download start

	// Hex digit to nibble, bit 4 flags a valid digit
	function automatic logic [4:0] hex_nibble(input logic [7:0] ch);
		logic [4:0] r;
		r = 5'd0;
		if (ch >= "0" && ch <= "9")
			r = {1'b1, ch[3:0]};
		else if (ch >= "A" && ch <= "F")
			r = {1'b1, ch[3:0] + 4'd9};
		return r;
	endfunction

	assign rom_dl    = download && (ioctl_index[4:0] < 5'd4); // ROM file types only
	assign byte_in   = rom_dl && ioctl_wr;
	assign slot_ok   = (ioctl_addr.sys.slot[10:3] == 8'd0);
	// Boot-time expansion files and manual loads fill both banks
	assign two_bank  = (ioctl_index[7:6] == 2'b01) || (|ioctl_index[5:0]);
	assign bank_step = two_bank && (boot_bank == 2'd0);

	assign page_mark_page = boot_addr[21:14];

	always_comb begin
		case (ioctl_addr.sys.slot[1:0])
			2'd0: sys_base = SLOT_BASE_OS;
			2'd1: sys_base = SLOT_BASE_BASIC;
			2'd2: sys_base = SLOT_BASE_AMSDOS;
			default: sys_base = SLOT_BASE_MF2;
		endcase
	end

	// Page from the two-character extension
	always_comb begin
		logic [4:0] hi;
		logic [4:0] lo;
		hi = hex_nibble(ioctl_ext[15:8]);
		lo = hex_nibble(ioctl_ext[7:0]);
		ext_page = PAGE_BAD_EXT;
		if (hi[4])
			ext_page[7:4] = hi[3:0];
		if (lo[4])
			ext_page[3:0] = lo[3:0];
		if (ioctl_ext == "ZZ")
			ext_page = 9'h000;
	end

	//////////////////////////////////////////////////////////////////////
	// Reference enable divider
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div    <= 3'd0;
			ref_en <= 1'b0;
		end else begin
			div    <= div + 3'd1;
			ref_en <= (div == 3'd0);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Write sequence
	always_ff @(posedge clk_sys) begin
		old_download <= download;
		page_mark    <= 1'b0;
		if (reset) begin
			dl_wait <= 1'b0;
			boot_wr <= 1'b0;
		end else begin
			if (byte_in)
				dl_wait <= (|ioctl_index) || slot_ok; // Unknown slots are dropped
			if (ref_en) begin
				boot_wr <= dl_wait;
				if (boot_wr && dl_wait) begin
					boot_wr <= 1'b0;
					if (!bank_step) begin
						dl_wait   <= 1'b0;
						page_mark <= boot_addr[22]; // Expansion page now loaded
					end
				end
			end
		end
	end

	// Address, bank and data for the pending write
	always_ff @(posedge clk_sys) begin
		if (download && !old_download && rom_dl && (|ioctl_index))
			page <= ext_page;
		if (byte_in) begin
			boot_data       <= ioctl_data;
			boot_addr[13:0] <= ioctl_addr.sys.offset;
			if (|ioctl_index) begin
				boot_addr[22]    <= page[8];
				boot_addr[21:14] <= page[7:0] + ioctl_addr.exp.page;
				boot_bank        <= {1'b0, &ioctl_index[7:6]};
			end else begin
				boot_addr[22:14] <= sys_base;
				boot_bank        <= {1'b0, ioctl_addr.sys.slot[2]}; // Slots 4-7 in bank 1
			end
		end
		if (ref_en && boot_wr && dl_wait && bank_step)
			boot_bank <= 2'd1;
	end

	// A write strobe only exists inside a wait window
	a_wr_in_wait: assert property (@(posedge clk_sys) disable iff (reset)
		boot_wr |-> dl_wait);

	// Each write strobe lasts one full reference period
	a_wr_width: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(boot_wr) |-> boot_wr [*8]);

endmodule

// File: source/rom_page_map.sv
// Expansion ROM page map
// Records which expansion pages have been loaded and masks CPU reads
// of pages that hold no ROM

module rom_page_map (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               page_mark,
	input  logic [7:0]         page_mark_page,
	input  cpc_pkg::mf2_mode_t mf2_mode,
	cpu_bus_if.map_sink        bus,
	output logic               rom_mask
);
	import cpc_pkg::*;

	logic [255:0] loaded;      // One flag per expansion page
	logic [7:0]   map_page;
	logic         mf2_page;

	always_ff @(posedge clk_sys) begin
		if (reset)
			loaded <= '0;
		else if (page_mark)
			loaded[page_mark_page] <= 1'b1;
	end

	// Registered page select for the lookup
	always_ff @(posedge clk_sys) begin
		map_page <= bus.mem_addr[21:14];
	end

	// Page FF holds the Multiface ROM, hidden when it is disabled
	assign mf2_page = (&map_page) && (mf2_mode == DISABLED);

	assign rom_mask = bus.mem_addr[22] && (!loaded[map_page] || mf2_page);

endmodule

// File: source/mf2_control.sv
// Multiface Two
// NMI entry on the freeze key, enable and hide control through the
// FEE8 and FEEA ports, shadowing of gate array, CRTC, PPI and ROM
// select writes, and the 8 KB RAM seen by the CPU

module mf2_control (
	input  logic               clk_sys,
	input  logic               reset,
	input  cpc_pkg::mf2_mode_t mf2_mode,
	input  logic               key_nmi,
	cpu_bus_if.sink            bus,
	output logic               nmi,
	output logic               mf2_rom_en,
	output logic               mf2_ram_en,
	output logic [7:0]         mf2_dout,
	output logic               mf2_active
);
	import cpc_pkg::*;

	logic        old_key_nmi;
	logic        old_m1;
	logic        old_io_wr;
	logic        key_rise;
	logic        m1_rise;
	logic        io_rise;
	logic        port_wr;      // Write to FEE8 or FEEA
	logic        hidden;
	logic        nmi_next;
	logic        active_next;
	logic        hidden_next;
	logic [4:0]  pen_index;
	logic [3:0]  crtc_reg;
	logic [12:0] store_addr;
	logic        shadow_wr;

	logic [7:0]  ram [8192];
	logic [12:0] ram_a;
	logic        ram_we;
	logic [7:0]  ram_in;
	logic [7:0]  ram_out;

	assign key_rise = key_nmi && !old_key_nmi;
	assign m1_rise  = bus.m1 && !old_m1;
	assign io_rise  = bus.io_wr && !old_io_wr;
	assign port_wr  = io_rise && (bus.cpu_addr[15:2] == MF2_PORT_HI);

	assign mf2_rom_en = mf2_active && (bus.cpu_addr[15:13] == 3'b000);
	assign mf2_ram_en = mf2_active && (bus.cpu_addr[15:13] == 3'b001);
	assign mf2_dout   = (mf2_ram_en && bus.mem_rd) ? ram_out : 8'hFF;

	//////////////////////////////////////////////////////////////////////
	// Shadow address decode
	always_comb begin
		store_addr = 13'h0000;                         // No shadow
		case (bus.cpu_addr[15:8])
			8'h7F: begin                               // Gate array
				case (bus.cpu_dout[7:6])
					2'b00: store_addr = MF2_SHADOW_PEN;
					2'b01: store_addr = pen_index[4] ? MF2_SHADOW_BORDER :
						{MF2_SHADOW_PEN_BASE[12:4], pen_index[3:0]};
					2'b10: store_addr = MF2_SHADOW_MODE;
					default: store_addr = MF2_SHADOW_BANK;
				endcase
			end
			8'hBC: store_addr = MF2_SHADOW_CRTC_SEL;
			8'hBD: store_addr = {MF2_SHADOW_CRTC_BASE[12:4], crtc_reg};
			8'hF7: store_addr = MF2_SHADOW_PPI;            // 8255 control
			8'hDF: store_addr = MF2_SHADOW_UROM;           // Upper ROM select
			default: store_addr = 13'h0000;
		endcase
	end

	assign shadow_wr = io_rise && !port_wr && (|store_addr);

	//////////////////////////////////////////////////////////////////////
	// NMI, enable and hide state
	always_comb begin
		nmi_next    = nmi;
		active_next = mf2_active;
		hidden_next = hidden;
		if (key_rise && !mf2_active && (mf2_mode != DISABLED))
			nmi_next = 1'b1;
		if (nmi && m1_rise && (bus.cpu_addr == MF2_NMI_VECTOR)) begin
			active_next = 1'b1;
			hidden_next = 1'b0;
			nmi_next    = 1'b0;
		end
		if (mf2_active && m1_rise && (bus.cpu_addr == MF2_HIDE_VECTOR))
			hidden_next = 1'b1;
		if (port_wr)
			active_next = !bus.cpu_addr[1] && !hidden; // FEE8 on, FEEA off
		if (active_next)
			nmi_next = 1'b0;                           // Pending NMI consumed
	end

	always_ff @(posedge clk_sys) begin
		old_key_nmi <= key_nmi;
		old_m1      <= bus.m1;
		old_io_wr   <= bus.io_wr;
		if (reset) begin
			nmi        <= 1'b0;
			mf2_active <= 1'b0;
			hidden     <= (mf2_mode != ENABLED);
			ram_we     <= 1'b0;
		end else begin
			nmi        <= nmi_next;
			mf2_active <= active_next;
			hidden     <= hidden_next;
			ram_we     <= shadow_wr || (bus.mem_wr && mf2_ram_en);
		end
	end

	// RAM address, data and register trackers
	always_ff @(posedge clk_sys) begin
		ram_in <= bus.cpu_dout;
		ram_a  <= shadow_wr ? store_addr : bus.mem_addr[12:0];
		if (shadow_wr && bus.cpu_addr[15:8] == 8'h7F && bus.cpu_dout[7:6] == 2'b00)
			pen_index <= bus.cpu_dout[4:0];
		if (shadow_wr && bus.cpu_addr[15:8] == 8'hBC)
			crtc_reg <= bus.cpu_dout[3:0];
	end

	//////////////////////////////////////////////////////////////////////
	// 8 KB RAM, write data shows on the read port
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_in;
			ram_out    <= ram_in;
		end else begin
			ram_out <= ram[ram_a];
		end
	end

	a_rom_ram_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(mf2_rom_en && mf2_ram_en));

	a_nmi_not_active: assert property (@(posedge clk_sys) disable iff (reset)
		!(nmi && mf2_active));

endmodule

// File: source/cpc_expansion_top.sv
// CPC expansion top level
// Joins the ROM loader, expansion page map and Multiface Two to the
// host download port and the CPU bus

module cpc_expansion_top (
	input  logic                clk_sys,
	input  logic                reset,

	// Host download
	input  logic                download,
	input  logic                ioctl_wr,
	input  logic [7:0]          ioctl_index,
	input  logic [24:0]         ioctl_addr,
	input  logic [7:0]          ioctl_data,
	input  logic [15:0]         ioctl_ext,
	input  cpc_pkg::mf2_mode_t  mf2_mode,

	// CPU bus
	input  logic [15:0]         cpu_addr,
	input  logic [7:0]          cpu_dout,
	input  cpc_pkg::boot_addr_t mem_addr,
	input  logic                mem_rd,
	input  logic                mem_wr,
	input  logic                io_wr,
	input  logic                m1,
	input  logic                key_nmi,

	// Boot memory writes
	output logic                dl_wait,
	output logic                boot_wr,
	output cpc_pkg::boot_addr_t boot_addr,
	output logic [1:0]          boot_bank,
	output logic [7:0]          boot_data,

	// Memory steering and Multiface
	output logic                rom_mask,
	output logic                mf2_rom_en,
	output logic                mf2_ram_en,
	output logic [7:0]          mf2_dout,
	output logic                nmi,
	output logic                mf2_active
);

	logic       page_mark;
	logic [7:0] page_mark_page;

	cpu_bus_if bus ();

	assign bus.cpu_addr = cpu_addr;
	assign bus.cpu_dout = cpu_dout;
	assign bus.mem_addr = mem_addr;
	assign bus.mem_rd   = mem_rd;
	assign bus.mem_wr   = mem_wr;
	assign bus.io_wr    = io_wr;
	assign bus.m1       = m1;

	rom_loader u_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.download       (download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_ext      (ioctl_ext),
		.dl_wait        (dl_wait),
		.boot_wr        (boot_wr),
		.boot_addr      (boot_addr),
		.boot_bank      (boot_bank),
		.boot_data      (boot_data),
		.page_mark      (page_mark),
		.page_mark_page (page_mark_page)
	);

	rom_page_map u_page_map (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.page_mark      (page_mark),
		.page_mark_page (page_mark_page),
		.mf2_mode       (mf2_mode),
		.bus            (bus.map_sink),
		.rom_mask       (rom_mask)
	);

	mf2_control u_mf2 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.mf2_mode   (mf2_mode),
		.key_nmi    (key_nmi),
		.bus        (bus.sink),
		.nmi        (nmi),
		.mf2_rom_en (mf2_rom_en),
		.mf2_ram_en (mf2_ram_en),
		.mf2_dout   (mf2_dout),
		.mf2_active (mf2_active)
	);

endmodule

// File: verification/tb_tasks.svh
// Testbench stimulus tasks
// Host download bytes, M1 fetches, I/O writes, memory reads and ROM
// mask probes. Each task starts and ends just after a falling edge

`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// One download byte, then follow the boot writes until dl_wait drops
task automatic load_byte(input logic [7:0] index, input logic [15:0] ext,
		input logic [24:0] addr, input boot_addr_t addr_exp,
		input logic [1:0] bank_exp, input int writes_exp);
	int   writes;
	int   n;
	logic prev;
	writes      = 0;
	n           = 0;
	download    = 1'b1;
	ioctl_index = index;
	ioctl_ext   = ext;
	@(negedge clk_sys);                 // Page latches on the download edge
	exp_addr   = addr_exp;
	exp_bank   = bank_exp;
	exp_data   = addr[7:0] ^ 8'h5A;
	ioctl_addr = addr;
	ioctl_data = exp_data;
	ioctl_wr   = 1'b1;
	@(negedge clk_sys);
	ioctl_wr = 1'b0;
	if (writes_exp == 0) begin
		drop_chk = 1'b1;                // Spans two reference periods
		repeat (20) @(negedge clk_sys);
		drop_chk = 1'b0;
	end
	while (dl_wait && n < 64) begin
		prev = boot_wr;
		@(negedge clk_sys);
		if (boot_wr && !prev)
			writes++;
		if (!boot_wr && prev)
			exp_bank = 2'd1;            // A second pass goes to bank 1
		n++;
	end
	if (dl_wait)
		log_error("download stalled, dl_wait still high after 64 cycles");
	assert (writes == writes_exp)
		else log_error($sformatf("%0d boot writes, expected %0d", writes, writes_exp));
	download = 1'b0;
	@(negedge clk_sys);
endtask

task automatic m1_fetch(input logic [15:0] addr);
	cpu_addr = addr;
	m1       = 1'b1;
	@(negedge clk_sys);
	m1 = 1'b0;
	@(negedge clk_sys);
endtask

task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
	cpu_addr = addr;
	cpu_dout = data;
	io_wr    = 1'b1;
	@(negedge clk_sys);
	io_wr = 1'b0;
	repeat (2) @(negedge clk_sys);      // Shadow store lands two cycles later
endtask

task automatic mem_read(input logic [15:0] cpu_a, input boot_addr_t mem_a,
		input logic [7:0] expected);
	cpu_addr = cpu_a;
	mem_addr = mem_a;
	mem_rd   = 1'b1;
	repeat (2) @(negedge clk_sys);      // RAM read latency
	exp_dout = expected;
	rd_chk   = 1'b1;
	@(negedge clk_sys);
	rd_chk = 1'b0;
	mem_rd = 1'b0;
endtask

task automatic probe_mask(input logic [7:0] page, input logic expected);
	mem_addr = {1'b1, page, 14'h0100};
	@(negedge clk_sys);                 // Page register loads
	exp_mask = expected;
	mask_chk = 1'b1;
	@(negedge clk_sys);
	mask_chk = 1'b0;
	mem_addr = '0;
endtask

task automatic key_press();
	key_nmi = 1'b1;
	repeat (2) @(negedge clk_sys);
	key_nmi = 1'b0;
	@(negedge clk_sys);
endtask

`endif

// File: verification/tb_cpc_expansion.sv
// CPC expansion testbench
// Runs ROM downloads, Multiface NMI entry, register shadowing and hide
// control through the top level, checked by concurrent assertions

module tb_cpc_expansion;
	timeunit 1ns;
	timeprecision 1ps;
	import cpc_pkg::*;

	localparam int TIMEOUT_CYCLES = 4000;   // About ten times the full sequence

	logic        clk_sys, reset, download, ioctl_wr, mem_rd, mem_wr, io_wr, m1, key_nmi;
	logic [7:0]  ioctl_index, ioctl_data, cpu_dout, boot_data, mf2_dout;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_ext, cpu_addr;
	boot_addr_t  mem_addr, boot_addr;
	logic [1:0]  boot_bank;
	mf2_mode_t   mf2_mode;
	logic        dl_wait, boot_wr, rom_mask, mf2_rom_en, mf2_ram_en, nmi, mf2_active;

	// Expected values and check windows, set by the stimulus
	boot_addr_t  exp_addr;
	logic [1:0]  exp_bank;
	logic [7:0]  exp_data, exp_dout;
	logic        exp_mask, exp_hidden, drop_chk, mask_chk, rd_chk;
	logic        exp_rom_en, exp_ram_en, en_chk;
	int          errors, errors_mark, passed, failed, cycles, seed;
	logic [31:0] rnd;
	logic [13:0] off;

	cpc_expansion_top u_dut (.*);

	`include "tb_tasks.svh"

	task automatic log_error(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		errors++;
	endtask

	task automatic end_test(input string name);
		if (errors == errors_mark) begin
			passed++;
			$display("Test %s: ok", name);
		end else begin
			failed++;
			$display("Test %s: failed with %0d errors", name, errors - errors_mark);
		end
		errors_mark = errors;
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	a_boot_write: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(boot_wr) |-> boot_addr == exp_addr && boot_bank == exp_bank && boot_data == exp_data)
		else log_error($sformatf("boot write differs from %h bank %0d", exp_addr, exp_bank));
	a_slot_drop: assert property (@(posedge clk_sys) disable iff (reset)
		drop_chk |-> !dl_wait && !boot_wr) else log_error("unknown slot was written");
	a_rom_mask: assert property (@(posedge clk_sys) disable iff (reset)
		mask_chk |-> rom_mask == exp_mask) else log_error($sformatf("rom_mask not %b", exp_mask));
	a_nmi_key: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(key_nmi) && !mf2_active && !nmi |=> nmi == (mf2_mode != DISABLED))
		else log_error("nmi wrong after a key press");
	a_nmi_entry: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(m1) && cpu_addr == 16'h0066 && nmi |=> mf2_active && !nmi)
		else log_error("fetch at 0066 did not enter the Multiface");
	a_region: assert property (@(posedge clk_sys) disable iff (reset)
		en_chk |-> mf2_rom_en == exp_rom_en && mf2_ram_en == exp_ram_en)
		else log_error($sformatf("ROM and RAM enables not %b and %b", exp_rom_en, exp_ram_en));
	a_ram_read: assert property (@(posedge clk_sys) disable iff (reset)
		rd_chk |-> mf2_dout == exp_dout) else log_error($sformatf("mf2_dout not %h", exp_dout));
	a_dout_idle: assert property (@(posedge clk_sys) disable iff (reset)
		!mem_rd |-> mf2_dout == 8'hFF) else log_error("idle mf2_dout not FF");
	a_port_off: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(io_wr) && cpu_addr == 16'hFEEA |=> !mf2_active)
		else log_error("write to FEEA left the Multiface active");
	a_port_on: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(io_wr) && cpu_addr == 16'hFEE8 |=> mf2_active == !exp_hidden)
		else log_error("write to FEE8 gave the wrong active state");

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		{download, ioctl_wr, mem_rd, mem_wr, io_wr, m1, key_nmi} = '0;
		{ioctl_index, ioctl_addr, ioctl_data, ioctl_ext} = '0;
		{cpu_addr, cpu_dout, mem_addr} = '0;
		{drop_chk, mask_chk, rd_chk, en_chk, exp_hidden, exp_mask} = '0;
		{exp_addr, exp_bank, exp_data, exp_dout, exp_rom_en, exp_ram_en} = '0;
		{errors, errors_mark, passed, failed} = '0;
		mf2_mode = ENABLED;
		seed     = 31;
		reset    = 1'b1;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;

		rnd = $random(seed);
		off = rnd[13:0];
		load_byte(8'd0, "  ", {11'd1, off}, {9'h100, off}, 2'd0, 1);
		load_byte(8'd0, "  ", {11'd5, off}, {9'h100, off}, 2'd1, 1);  // Slots 4-7 in bank 1
		load_byte(8'd0, "  ", {11'd9, off}, '0, 2'd0, 0);
		end_test("system ROM download");

		rnd = $random(seed);
		off = rnd[13:0];
		probe_mask(8'h07, 1'b1);                                        // Not loaded yet
		load_byte(8'd3, "07", {3'd0, 8'h00, off}, {1'b1, 8'h07, off}, 2'd0, 2);
		probe_mask(8'h07, 1'b0);
		probe_mask(8'h08, 1'b1);
		end_test("expansion download");

		key_press();
		m1_fetch(16'h0066);
		cpu_addr   = 16'h1234;                                          // Multiface ROM region
		exp_rom_en = 1'b1;
		exp_ram_en = 1'b0;
		en_chk     = 1'b1;
		@(negedge clk_sys);
		cpu_addr   = 16'h4321;
		exp_rom_en = 1'b0;
		@(negedge clk_sys);
		en_chk = 1'b0;
		end_test("NMI entry");

		io_write(16'h7F00, 8'h05);                                      // Pen select
		io_write(16'h7F00, 8'h4A);                                      // Colour for pen 5
		mem_read(16'h3F95, 23'h001F95, 8'h4A);
		mem_read(16'h8F95, 23'h001F95, 8'hFF);
		end_test("register shadow");

		m1_fetch(16'h0065);
		exp_hidden = 1'b1;
		io_write(16'hFEEA, 8'h00);
		io_write(16'hFEE8, 8'h00);
		load_byte(8'd3, "FF", {3'd0, 8'h00, off}, {1'b1, 8'hFF, off}, 2'd0, 2);
		probe_mask(8'hFF, 1'b0);
		mf2_mode = DISABLED;
		key_press();
		probe_mask(8'hFF, 1'b1);
		end_test("hide and disable");

		$display("Tests: %0d passed, %0d failed, %0d check errors", passed, failed, errors);
		if (failed == 0 && errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// File: tb.f
+incdir+verification
source/cpc_pkg.sv
source/cpu_bus_if.sv
source/rom_loader.sv
source/rom_page_map.sv
source/mf2_control.sv
source/cpc_expansion_top.sv
verification/tb_cpc_expansion.sv

// File: Makefile
SOURCES := $(wildcard source/*.sv verification/*.sv verification/*.svh)

.PHONY: all run clean

all: run

obj_dir/Vtb_cpc_expansion: tb.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_cpc_expansion -f tb.f -o Vtb_cpc_expansion

run: obj_dir/Vtb_cpc_expansion
	@./obj_dir/Vtb_cpc_expansion > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@! grep -q "RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
